// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/reg_file.sv
      - design/decode.sv
      - design/execute.sv
      - design/cpu.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/cpu_props.sv
      - testbench/cpu_checker.sv
      - testbench/cpu_tb.sv

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // one instruction per strobe
    input  logic      instr_valid,
    input  instr_t    instr,
    // register write, one pulse per writing instruction
    output logic      wb_valid,
    output reg_addr_t wb_sel,
    output data_t     wb_data
);

    //////////////////////////////////////////////////////////////////////
    // decode to execute
    //////////////////////////////////////////////////////////////////////

    logic      ex_valid;
    opcode_t   ex_op;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    data_t     ex_a;
    data_t     ex_b;
    imm_t      ex_imm;

    // fetch capture, decode, register read
    decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        // writeback loops back into the register file
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_imm      (ex_imm)
    );

    // forwarding, alu, writeback register
    execute i_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_rd    (ex_rd),
        .ex_rs1   (ex_rs1),
        .ex_rs2   (ex_rs2),
        .ex_a     (ex_a),
        .ex_b     (ex_b),
        .ex_imm   (ex_imm),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data)
    );

endmodule

// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// data path and register file
//////////////////////////////////////////////////////////////////////

// width of a register value and of the alu
`define CPU_XLEN      32
// architectural registers, register 0 hardwired to zero
`define CPU_NREGS     32
`define CPU_REG_AW    5

//////////////////////////////////////////////////////////////////////
// instruction word layout
//////////////////////////////////////////////////////////////////////

// opcode bounds
`define CPU_OP_MSB    31
`define CPU_OP_LSB    27
// low bits of the register fields, each CPU_REG_AW wide
`define CPU_RD_LSB    22
`define CPU_RS1_LSB   17
`define CPU_RS2_LSB   12
// immediate sits in the low bits and overlaps rs2
`define CPU_IMM_W     17
// lui puts the immediate at the top of the word
`define CPU_LUI_SHIFT 15

`endif

// ==== design/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    // one register value
    typedef logic [`CPU_XLEN-1:0] data_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // register index
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // immediate field before extension
    typedef logic [`CPU_IMM_W-1:0] imm_t;

    //////////////////////////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////////////////////////

    // codes 10..31 are not listed and act as nops
    typedef enum logic [`CPU_OP_MSB-`CPU_OP_LSB:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_xor  = 5'd4,
        op_sll  = 5'd5,
        op_srl  = 5'd6,
        op_slt  = 5'd7,
        op_addi = 5'd8,
        op_lui  = 5'd9
    } opcode_t;

endpackage

// ==== design/decode.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module decode
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // instruction strobe from outside
    input  logic      instr_valid,
    input  instr_t    instr,
    // writeback port, goes straight to the register file
    input  logic      wb_valid,
    input  reg_addr_t wb_sel,
    input  data_t     wb_data,
    // decode/execute register
    output logic      ex_valid,
    output opcode_t   ex_op,
    output reg_addr_t ex_rd,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output data_t     ex_a,
    output data_t     ex_b,
    output imm_t      ex_imm
);

    // fetch register
    logic      fe_valid;
    instr_t    fe_instr;

    // fields of the captured word
    opcode_t   fe_op;
    reg_addr_t fe_rd;
    reg_addr_t fe_rs1;
    reg_addr_t fe_rs2;
    imm_t      fe_imm;

    // control
    logic      op_known;

    // source values out of the register file
    data_t     rf_a;
    data_t     rf_b;

    //////////////////////////////////////////////////////////////////////
    // fetch capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fe_valid <= 1'b0;
        end else begin
            // a gap in the strobe becomes a bubble
            fe_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        fe_instr <= instr;
    end

    //////////////////////////////////////////////////////////////////////
    // field split and control
    //////////////////////////////////////////////////////////////////////

    assign fe_op  = opcode_t'(fe_instr[`CPU_OP_MSB:`CPU_OP_LSB]);
    assign fe_rd  = fe_instr[`CPU_RD_LSB +: `CPU_REG_AW];
    assign fe_rs1 = fe_instr[`CPU_RS1_LSB +: `CPU_REG_AW];
    assign fe_rs2 = fe_instr[`CPU_RS2_LSB +: `CPU_REG_AW];
    // imm overlaps rs2
    assign fe_imm = fe_instr[`CPU_IMM_W-1:0];

    // anything outside the table is a nop
    always_comb begin
        case (fe_op)
            op_add, op_sub, op_and, op_or, op_xor,
            op_sll, op_srl, op_slt, op_addi, op_lui: op_known = 1'b1;
            default:                                 op_known = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // register read
    //////////////////////////////////////////////////////////////////////

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (fe_rs1),
        .rd_addr_b (fe_rs2),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (wb_valid),
        .wr_addr   (wb_sel),
        .wr_data   (wb_data)
    );

    //////////////////////////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////////////////////////

    // only real register writes go on as valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= fe_valid && op_known && (fe_rd != '0);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        ex_op  <= fe_op;
        ex_rd  <= fe_rd;
        ex_rs1 <= fe_rs1;
        ex_rs2 <= fe_rs2;
        ex_a   <= rf_a;
        ex_b   <= rf_b;
        ex_imm <= fe_imm;
    end

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module execute
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // decode/execute register
    input  logic      ex_valid,
    input  opcode_t   ex_op,
    input  reg_addr_t ex_rd,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  data_t     ex_a,
    input  data_t     ex_b,
    input  imm_t      ex_imm,
    // execute/writeback register
    output logic      wb_valid,
    output reg_addr_t wb_sel,
    output data_t     wb_data
);

    // operands after forwarding
    data_t op_a;
    data_t op_b;

    // immediate forms
    data_t imm_sext;
    data_t imm_upper;

    data_t alu_result;

    //////////////////////////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////////////////////////

    // previous result overrides a stale register read
    // register 0 never forwards
    assign op_a = (wb_valid && (wb_sel == ex_rs1) && (ex_rs1 != '0)) ? wb_data : ex_a;
    assign op_b = (wb_valid && (wb_sel == ex_rs2) && (ex_rs2 != '0)) ? wb_data : ex_b;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    // addi operand
    assign imm_sext  = {{(`CPU_XLEN-`CPU_IMM_W){ex_imm[`CPU_IMM_W-1]}}, ex_imm};
    // lui value, zeros below the shift point
    assign imm_upper = data_t'(ex_imm) << `CPU_LUI_SHIFT;

    always_comb begin
        case (ex_op)
            op_add:  alu_result = op_a + op_b;
            op_sub:  alu_result = op_a - op_b;
            op_and:  alu_result = op_a & op_b;
            op_or:   alu_result = op_a | op_b;
            op_xor:  alu_result = op_a ^ op_b;
            // shift amount from low 5 bits of rs2
            op_sll:  alu_result = op_a << op_b[4:0];
            op_srl:  alu_result = op_a >> op_b[4:0];
            op_slt:  alu_result = ($signed(op_a) < $signed(op_b)) ? data_t'(1) : '0;
            op_addi: alu_result = op_a + imm_sext;
            op_lui:  alu_result = imm_upper;
            // unknown codes never arrive valid
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // execute/writeback register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    // destination and result
    always_ff @(posedge clk) begin
        wb_sel  <= ex_rd;
        wb_data <= alu_result;
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // two read ports, combinational
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output data_t     rd_data_a,
    output data_t     rd_data_b,
    // single write port from writeback
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data
);

    // register array
    data_t regs [`CPU_NREGS];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // whole file starts at zero
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // register 0 never takes a write
            regs[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // zero register first, then write-through of the value landing this edge
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_a)) ? wr_data :
                       regs[rd_addr_a];

    // same rules for the second source
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_b)) ? wr_data :
                       regs[rd_addr_b];

endmodule

// ==== files.f ====
+incdir+design
design/cpu_pkg.sv
design/reg_file.sv
design/decode.sv
design/execute.sv
design/cpu.sv
testbench/cpu_props.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_checker
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      wb_valid,
    input  reg_addr_t wb_sel,
    input  data_t     wb_data,
    output int        error_count,
    output int        check_count,
    output int        pending_count
);

    // reference register file, x0 is never written
    data_t model_regs [`CPU_NREGS];

    // expected writes, oldest first
    reg_addr_t exp_sel [$];
    data_t     exp_data [$];
    int        exp_due [$];

    // edges counted from the end of reset
    int edge_count;

    // value of an instruction against the current model state
    function automatic data_t model_result(instr_t word);
        data_t a;
        data_t b;
        logic [`CPU_IMM_W-1:0] imm;
        a   = model_regs[word[`CPU_RS1_LSB +: `CPU_REG_AW]];
        b   = model_regs[word[`CPU_RS2_LSB +: `CPU_REG_AW]];
        imm = word[`CPU_IMM_W-1:0];
        case (word[`CPU_OP_MSB:`CPU_OP_LSB])
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_addi: return a + {{(`CPU_XLEN-`CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};
            op_lui:  return {imm, 15'd0};
            default: return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        reg_addr_t  rd;
        logic [4:0] code;
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                model_regs[i] = '0;
            end
            exp_sel.delete();
            exp_data.delete();
            exp_due.delete();
            edge_count  = 0;
            error_count = 0;
            check_count = 0;
        end else begin
            edge_count++;
            // compare the writeback register against the oldest record
            if (exp_due.size() > 0 && exp_due[0] == edge_count) begin
                check_count++;
                if (wb_valid !== 1'b1 || wb_sel !== exp_sel[0] || wb_data !== exp_data[0]) begin
                    error_count++;
                    $display("Fail at %0t: expected x%0d = %h, got valid %b x%0d = %h",
                             $time, exp_sel[0], exp_data[0], wb_valid, wb_sel, wb_data);
                end
                void'(exp_sel.pop_front());
                void'(exp_data.pop_front());
                void'(exp_due.pop_front());
            end else if (wb_valid !== 1'b0) begin
                error_count++;
                $display("Fail at %0t: writeback x%0d = %h with none due (valid %b)",
                         $time, wb_sel, wb_data, wb_valid);
            end
            // new instruction, pulse due three edges on
            rd   = instr[`CPU_RD_LSB +: `CPU_REG_AW];
            code = instr[`CPU_OP_MSB:`CPU_OP_LSB];
            if (instr_valid && code <= 5'd9 && rd != '0) begin
                model_regs[rd] = model_result(instr);
                exp_sel.push_back(rd);
                exp_data.push_back(model_regs[rd]);
                exp_due.push_back(edge_count + 3);
            end
        end
        pending_count = exp_due.size();
    end

endmodule

// ==== testbench/cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      wb_valid,
    input reg_addr_t wb_sel
);

    // number of failed assertions
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // writeback port
    //////////////////////////////////////////////////////////////////////

    // pipeline comes out of reset empty
    quiet_after_reset: assert property (
        @(posedge clk) !rst_n |=> !wb_valid
    ) else begin
        $error("wb_valid high in the cycle after reset");
        fail_count++;
    end

    // x0 writes are dropped in decode
    no_zero_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_sel != '0)
    ) else begin
        $error("writeback pulse with destination x0");
        fail_count++;
    end

    // valid is always driven
    valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_valid)
    ) else begin
        $error("wb_valid unknown out of reset");
        fail_count++;
    end

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_tb
    import cpu_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////////////////////////

    localparam int reset_cycles   = 8;
    localparam int test_cycles    = 400;
    localparam int drain_cycles   = 10;
    // slack on top of the nominal run
    localparam int margin_cycles  = 82;
    localparam int timeout_cycles = reset_cycles + test_cycles + drain_cycles + margin_cycles;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      wb_valid;
    reg_addr_t wb_sel;
    data_t     wb_data;

    // counts from the checker
    int error_count;
    int check_count;
    int pending_count;

    // failures of the bound assertions
    int assert_fail_count;

    int seed;
    int cycle_count;

    cpu i_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

    // reference model and writeback compare
    cpu_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_sel        (wb_sel),
        .wb_data       (wb_data),
        .error_count   (error_count),
        .check_count   (check_count),
        .pending_count (pending_count)
    );

    // protocol assertions on the top level
    bind cpu cpu_props i_cpu_props (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel)
    );

    // 40 ns period
    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // opcodes 10 and 11 are unknown
    // registers limited to x0..x7
    task automatic drive_random_instr();
        instr_t     word;
        logic [4:0] code;
        word = $random(seed);
        code = 5'($unsigned($random(seed)) % 12);
        word[`CPU_OP_MSB:`CPU_OP_LSB]      = code;
        word[`CPU_RD_LSB +: `CPU_REG_AW]  = 5'($unsigned($random(seed)) % 8);
        word[`CPU_RS1_LSB +: `CPU_REG_AW] = 5'($unsigned($random(seed)) % 8);
        // addi and lui keep the full random immediate
        if (code != op_addi && code != op_lui) begin
            word[`CPU_RS2_LSB +: `CPU_REG_AW] = 5'($unsigned($random(seed)) % 8);
        end
        instr       = word;
        // roughly 80 percent strobes
        instr_valid = ($unsigned($random(seed)) % 10) < 8;
    endtask

    initial begin
        seed        = 63;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < test_cycles; i++) begin
            drive_random_instr();
            @(negedge clk);
        end
        // let the last writes come out
        instr_valid = 1'b0;
        repeat (drain_cycles) @(negedge clk);
        assert_fail_count = i_cpu.i_cpu_props.fail_count;
        $display("errors: %0d mismatches, %0d missing, %0d assertion failures, %0d checked",
                 error_count, pending_count, assert_fail_count, check_count);
        if (error_count == 0 && pending_count == 0 && assert_fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // timeout
    //////////////////////////////////////////////////////////////////////

    initial cycle_count = 0;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule
